//--- verilog/rvIsaPkg.sv
// RV32I instruction encoding: opcodes, funct3 codes and the six instruction formats
// used by the FSM, the datapath and the ALU through scoped names
package rvIsaPkg;

  localparam int xlen = 32;
  localparam int regCount = 32;

  typedef logic [xlen-1:0] wordT;

  typedef enum logic [6:0] {
    rType      = 7'b0110011,
    iTypeLogic = 7'b0010011,
    iTypeLoad  = 7'b0000011,
    iTypeJalr  = 7'b1100111,
    sType      = 7'b0100011,
    bType      = 7'b1100011,
    jType      = 7'b1101111,
    uTypeLui   = 7'b0110111,
    uTypeAuipc = 7'b0010111,
    fence      = 7'b0001111
  } opcodeT;

  // load and store widths
  localparam logic [2:0] f3Byte  = 3'b000;
  localparam logic [2:0] f3Half  = 3'b001;
  localparam logic [2:0] f3Word  = 3'b010;
  localparam logic [2:0] f3ByteU = 3'b100;
  localparam logic [2:0] f3HalfU = 3'b101;

  // alu operations for op and op-imm
  localparam logic [2:0] f3AddSub = 3'b000;
  localparam logic [2:0] f3Sll    = 3'b001;
  localparam logic [2:0] f3Slt    = 3'b010;
  localparam logic [2:0] f3Sltu   = 3'b011;
  localparam logic [2:0] f3Xor    = 3'b100;
  localparam logic [2:0] f3SrlSra = 3'b101;
  localparam logic [2:0] f3Or     = 3'b110;
  localparam logic [2:0] f3And    = 3'b111;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcodeT     opcode;
  } rFmtT;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcodeT      opcode;
  } iFmtT;

  typedef struct packed {
    logic [6:0] immHi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;
    opcodeT     opcode;
  } sFmtT;

  typedef struct packed {
    logic       imm12;
    logic [5:0] immHi;    // imm[10:5]
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] immLo;    // imm[4:1]
    logic       imm11;
    opcodeT     opcode;
  } bFmtT;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    opcodeT      opcode;
  } uFmtT;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10to1;
    logic       imm11;
    logic [7:0] imm19to12;
    logic [4:0] rd;
    opcodeT     opcode;
  } jFmtT;

  typedef union packed {
    rFmtT rFmt;
    iFmtT iFmt;
    sFmtT sFmt;
    bFmtT bFmt;
    uFmtT uFmt;
    jFmtT jFmt;
  } instrWordT;

endpackage

//--- verilog/rvCtrlPkg.sv
// control encoding between the FSM and the datapath: states, mux selects, alu classes
package rvCtrlPkg;

  localparam logic [31:0] resetPc = 32'h0000_0000;

  typedef enum logic [4:0] {
    fetch      = 5'd0,
    decode     = 5'd1,
    executeR   = 5'd2,
    executeI   = 5'd3,
    uncondJump = 5'd4,
    memAdr     = 5'd5,
    memRead    = 5'd6,
    memWrite   = 5'd7,
    memWb      = 5'd8,
    aluWb      = 5'd9,
    branchEq   = 5'd10,
    branchComp = 5'd11,
    lui        = 5'd12,
    auipc      = 5'd13,
    jalrCalc   = 5'd14,
    jalrLink   = 5'd15,
    primeFetch = 5'd16
  } fsmStateT;

  typedef enum logic {adrPc, adrAluOut} adrSrcT;
  typedef enum logic [1:0] {srcAPc, srcAOldPc, srcARegA, srcAZero} aluSrcAT;
  typedef enum logic [1:0] {srcBRegB, srcBImm, srcBFour} aluSrcBT;
  typedef enum logic [1:0] {resultAluOut, resultMdr, resultAluResult} resultSrcT;
  typedef enum logic [1:0] {pcIncrement, pcAluOut, pcAluResultClr} pcSrcT;
  typedef enum logic [1:0] {aluAdd, aluSubCmp, aluFunct} aluClassT;

endpackage

//--- verilog/ctrlIf.sv
// control strobes and selects from the FSM, instruction and flags back from the datapath
`timescale 1ns/1ps

interface ctrlIf;
  logic                  irWrite;
  logic                  regWrite;
  logic                  pcUpdate;
  rvCtrlPkg::adrSrcT     adrSrc;
  rvCtrlPkg::aluSrcAT    aluSrcA;
  rvCtrlPkg::aluSrcBT    aluSrcB;
  rvCtrlPkg::aluClassT   aluClass;
  rvCtrlPkg::resultSrcT  resultSrc;
  rvCtrlPkg::pcSrcT      pcSrc;
  logic [3:0]            memByteEn;  // read at the top level only

  rvIsaPkg::instrWordT   instr;
  logic                  zero;
  logic                  cmpBit;     // lsb of the alu result
  logic [3:0]            storeLanes;

  modport fsm (
    output irWrite, regWrite, pcUpdate, adrSrc, aluSrcA, aluSrcB, aluClass,
    output resultSrc, pcSrc, memByteEn,
    input  instr, zero, cmpBit, storeLanes
  );

  modport dp (
    input  irWrite, regWrite, pcUpdate, adrSrc, aluSrcA, aluSrcB, aluClass,
    input  resultSrc, pcSrc,
    output instr, zero, cmpBit, storeLanes
  );
endinterface

//--- verilog/alu.sv
// 32-bit combinational ALU, operation picked from the class, funct3 and funct7 bit 5
`timescale 1ns/1ps

module alu (
  input  rvIsaPkg::wordT      a,
  input  rvIsaPkg::wordT      b,
  input  rvCtrlPkg::aluClassT aluClass,
  input  logic [2:0]          funct3,
  input  logic                funct7b5,
  input  logic                isRegOp,
  output rvIsaPkg::wordT      result,
  output logic                zero
);

  logic       lessS;
  logic       lessU;
  logic [4:0] shamt;

  assign lessS = $signed(a) < $signed(b);
  assign lessU = a < b;
  assign shamt = b[4:0];

  always_comb begin
    result = '0;
    case (aluClass)
      rvCtrlPkg::aluAdd: result = a + b;
      rvCtrlPkg::aluSubCmp: begin
        if (!funct3[2]) begin
          result = a - b;  // equality via zero
        end else begin
          result = {{(rvIsaPkg::xlen-1){1'b0}}, funct3[1] ? lessU : lessS};
        end
      end
      default: begin
        case (funct3)
          rvIsaPkg::f3AddSub: result = (isRegOp && funct7b5) ? a - b : a + b;
          rvIsaPkg::f3Sll:    result = a << shamt;
          rvIsaPkg::f3Slt:    result = {{(rvIsaPkg::xlen-1){1'b0}}, lessS};
          rvIsaPkg::f3Sltu:   result = {{(rvIsaPkg::xlen-1){1'b0}}, lessU};
          rvIsaPkg::f3Xor:    result = a ^ b;
          // srai carries funct7b5 too, so no isRegOp check here
          rvIsaPkg::f3SrlSra: result = funct7b5 ? $unsigned($signed(a) >>> shamt) : a >> shamt;
          rvIsaPkg::f3Or:     result = a | b;
          rvIsaPkg::f3And:    result = a & b;
        endcase
      end
    endcase
  end

  assign zero = (result == '0);

endmodule

//--- verilog/controlFsm.sv
// Moore control FSM for the multicycle core, one state per clock
// outputs follow the state, branches also look at zero and cmpBit
`timescale 1ns/1ps

module controlFsm (
  input  logic                clk,
  input  logic                reset,
  ctrlIf.fsm                  ctl,
  output rvCtrlPkg::fsmStateT state
);

  rvCtrlPkg::fsmStateT nextState;
  rvIsaPkg::opcodeT    opcode;
  logic [2:0]          funct3;

  assign opcode = ctl.instr.rFmt.opcode;
  assign funct3 = ctl.instr.rFmt.funct3;

  always_comb begin
    case (state)
      rvCtrlPkg::fetch: nextState = rvCtrlPkg::decode;
      rvCtrlPkg::decode: begin
        case (opcode)
          rvIsaPkg::rType:      nextState = rvCtrlPkg::executeR;
          rvIsaPkg::iTypeLogic: nextState = rvCtrlPkg::executeI;
          rvIsaPkg::iTypeLoad:  nextState = rvCtrlPkg::memAdr;
          rvIsaPkg::sType:      nextState = rvCtrlPkg::memAdr;
          rvIsaPkg::jType:      nextState = rvCtrlPkg::uncondJump;
          rvIsaPkg::iTypeJalr:  nextState = rvCtrlPkg::jalrCalc;
          rvIsaPkg::uTypeLui:   nextState = rvCtrlPkg::lui;
          rvIsaPkg::uTypeAuipc: nextState = rvCtrlPkg::auipc;
          // beq/bne have funct3[2] clear, the four compares have it set
          rvIsaPkg::bType:
            nextState = funct3[2] ? rvCtrlPkg::branchComp : rvCtrlPkg::branchEq;
          default:              nextState = rvCtrlPkg::fetch;  // fence and unknown opcodes
        endcase
      end
      rvCtrlPkg::executeR,
      rvCtrlPkg::executeI,
      rvCtrlPkg::uncondJump,
      rvCtrlPkg::lui,
      rvCtrlPkg::auipc,
      rvCtrlPkg::jalrLink:  nextState = rvCtrlPkg::aluWb;
      rvCtrlPkg::memAdr:
        nextState = (opcode == rvIsaPkg::iTypeLoad) ? rvCtrlPkg::memRead : rvCtrlPkg::memWrite;
      rvCtrlPkg::memRead:   nextState = rvCtrlPkg::memWb;
      rvCtrlPkg::memWrite:  nextState = rvCtrlPkg::primeFetch;
      rvCtrlPkg::jalrCalc:  nextState = rvCtrlPkg::jalrLink;
      default:              nextState = rvCtrlPkg::fetch;
    endcase
  end

  always_comb begin
    ctl.irWrite   = 1'b0;
    ctl.regWrite  = 1'b0;
    ctl.pcUpdate  = 1'b0;
    ctl.adrSrc    = rvCtrlPkg::adrPc;
    ctl.aluSrcA   = rvCtrlPkg::srcARegA;
    ctl.aluSrcB   = rvCtrlPkg::srcBImm;
    ctl.aluClass  = rvCtrlPkg::aluAdd;
    ctl.resultSrc = rvCtrlPkg::resultAluOut;
    ctl.pcSrc     = rvCtrlPkg::pcIncrement;
    ctl.memByteEn = 4'b0000;

    case (state)
      rvCtrlPkg::fetch: begin
        ctl.irWrite   = 1'b1;
        ctl.pcUpdate  = 1'b1;
        ctl.aluSrcA   = rvCtrlPkg::srcAPc;  // pc + 4 goes through the alu
        ctl.aluSrcB   = rvCtrlPkg::srcBFour;
        ctl.resultSrc = rvCtrlPkg::resultAluResult;
      end
      rvCtrlPkg::decode: begin
        ctl.aluSrcA = rvCtrlPkg::srcAOldPc;  // branch / jal target lands in aluOut
      end
      rvCtrlPkg::executeR: begin
        ctl.aluSrcB  = rvCtrlPkg::srcBRegB;
        ctl.aluClass = rvCtrlPkg::aluFunct;
      end
      rvCtrlPkg::executeI: ctl.aluClass = rvCtrlPkg::aluFunct;
      rvCtrlPkg::uncondJump: begin
        ctl.aluSrcA  = rvCtrlPkg::srcAOldPc;  // link value
        ctl.aluSrcB  = rvCtrlPkg::srcBFour;
        ctl.pcSrc    = rvCtrlPkg::pcAluOut;
        ctl.pcUpdate = 1'b1;
      end
      rvCtrlPkg::memRead: ctl.adrSrc = rvCtrlPkg::adrAluOut;  // alu keeps the address in aluOut
      rvCtrlPkg::memWrite: begin
        ctl.adrSrc    = rvCtrlPkg::adrAluOut;
        ctl.memByteEn = ctl.storeLanes;
      end
      rvCtrlPkg::memWb: begin
        ctl.resultSrc = rvCtrlPkg::resultMdr;
        ctl.regWrite  = 1'b1;
      end
      rvCtrlPkg::aluWb: ctl.regWrite = 1'b1;
      rvCtrlPkg::branchEq: begin
        ctl.aluSrcB  = rvCtrlPkg::srcBRegB;
        ctl.aluClass = rvCtrlPkg::aluSubCmp;
        ctl.pcSrc    = rvCtrlPkg::pcAluOut;
        ctl.pcUpdate = ctl.zero ^ funct3[0];  // funct3[0] turns beq into bne
      end
      rvCtrlPkg::branchComp: begin
        ctl.aluSrcB  = rvCtrlPkg::srcBRegB;
        ctl.aluClass = rvCtrlPkg::aluSubCmp;
        ctl.pcSrc    = rvCtrlPkg::pcAluOut;
        ctl.pcUpdate = ctl.cmpBit ^ funct3[0];  // bge/bgeu are inverted blt/bltu
      end
      rvCtrlPkg::lui:   ctl.aluSrcA = rvCtrlPkg::srcAZero;
      rvCtrlPkg::auipc: ctl.aluSrcA = rvCtrlPkg::srcAOldPc;
      rvCtrlPkg::jalrCalc: begin
        ctl.pcSrc    = rvCtrlPkg::pcAluResultClr;  // rs1 + imm with bit 0 cleared
        ctl.pcUpdate = 1'b1;
      end
      rvCtrlPkg::jalrLink: begin
        ctl.aluSrcA = rvCtrlPkg::srcAOldPc;
        ctl.aluSrcB = rvCtrlPkg::srcBFour;
      end
      default: ;  // memAdr and primeFetch use the defaults
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= rvCtrlPkg::fetch;
    end else begin
      state <= nextState;
    end
  end

endmodule

//--- verilog/datapath.sv
// datapath of the multicycle core: pc, instruction and data registers, register file,
// immediate extension, load and store lane alignment around one alu
`timescale 1ns/1ps

module datapath (
  input  logic           clk,
  input  logic           reset,
  ctrlIf.dp              ctl,
  output rvIsaPkg::wordT memAddr,
  output rvIsaPkg::wordT memWriteData,
  input  rvIsaPkg::wordT memReadData
);

  rvIsaPkg::wordT      pc;
  rvIsaPkg::wordT      oldPc;
  rvIsaPkg::instrWordT instr;
  rvIsaPkg::wordT      mdr;
  rvIsaPkg::wordT      regA;
  rvIsaPkg::wordT      regB;
  rvIsaPkg::wordT      aluOut;
  rvIsaPkg::wordT      regFile [rvIsaPkg::regCount];

  logic [4:0]     rs1;
  logic [4:0]     rs2;
  logic [4:0]     rd;
  logic [2:0]     funct3;
  logic           isRegOp;
  rvIsaPkg::wordT rd1;
  rvIsaPkg::wordT rd2;
  rvIsaPkg::wordT immExt;
  rvIsaPkg::wordT srcA;
  rvIsaPkg::wordT srcB;
  rvIsaPkg::wordT aluResult;
  rvIsaPkg::wordT loadShifted;
  rvIsaPkg::wordT loadData;
  rvIsaPkg::wordT result;
  rvIsaPkg::wordT pcNext;

  assign rs1     = instr.rFmt.rs1;
  assign rs2     = instr.rFmt.rs2;
  assign rd      = instr.rFmt.rd;
  assign funct3  = instr.rFmt.funct3;
  assign isRegOp = (instr.rFmt.opcode == rvIsaPkg::rType);

  assign ctl.instr = instr;

  // x0 is hardwired to zero
  assign rd1 = (rs1 == 5'd0) ? '0 : regFile[rs1];
  assign rd2 = (rs2 == 5'd0) ? '0 : regFile[rs2];

  always_comb begin
    case (instr.rFmt.opcode)
      rvIsaPkg::sType:
        immExt = {{20{instr.sFmt.immHi[6]}}, instr.sFmt.immHi, instr.sFmt.immLo};
      rvIsaPkg::bType:
        immExt = {{19{instr.bFmt.imm12}}, instr.bFmt.imm12, instr.bFmt.imm11,
                  instr.bFmt.immHi, instr.bFmt.immLo, 1'b0};
      rvIsaPkg::uTypeLui,
      rvIsaPkg::uTypeAuipc:
        immExt = {instr.uFmt.imm, 12'b0};
      rvIsaPkg::jType:
        immExt = {{11{instr.jFmt.imm20}}, instr.jFmt.imm20, instr.jFmt.imm19to12,
                  instr.jFmt.imm11, instr.jFmt.imm10to1, 1'b0};
      default:
        immExt = {{20{instr.iFmt.imm[11]}}, instr.iFmt.imm};  // op-imm, loads, jalr
    endcase
  end

  always_comb begin
    case (ctl.aluSrcA)
      rvCtrlPkg::srcAPc:    srcA = pc;
      rvCtrlPkg::srcAOldPc: srcA = oldPc;
      rvCtrlPkg::srcARegA:  srcA = regA;
      default:              srcA = '0;
    endcase
    case (ctl.aluSrcB)
      rvCtrlPkg::srcBRegB: srcB = regB;
      rvCtrlPkg::srcBImm:  srcB = immExt;
      default:             srcB = 32'd4;
    endcase
  end

  alu i_alu (
    .a        (srcA),
    .b        (srcB),
    .aluClass (ctl.aluClass),
    .funct3   (funct3),
    .funct7b5 (instr.rFmt.funct7[5]),
    .isRegOp  (isRegOp),
    .result   (aluResult),
    .zero     (ctl.zero)
  );

  assign ctl.cmpBit = aluResult[0];

  // loads pick their lane out of the word read, aluOut still holds the address
  assign loadShifted = mdr >> {aluOut[1:0], 3'b000};

  always_comb begin
    case (funct3)
      rvIsaPkg::f3Byte:  loadData = {{24{loadShifted[7]}}, loadShifted[7:0]};
      rvIsaPkg::f3Half:  loadData = {{16{loadShifted[15]}}, loadShifted[15:0]};
      rvIsaPkg::f3ByteU: loadData = {24'b0, loadShifted[7:0]};
      rvIsaPkg::f3HalfU: loadData = {16'b0, loadShifted[15:0]};
      rvIsaPkg::f3Word:  loadData = mdr;
      default:           loadData = mdr;
    endcase
  end

  always_comb begin
    case (funct3)
      rvIsaPkg::f3Byte: ctl.storeLanes = 4'b0001 << aluOut[1:0];
      rvIsaPkg::f3Half: ctl.storeLanes = 4'b0011 << {aluOut[1], 1'b0};
      default:          ctl.storeLanes = 4'b1111;  // f3Word
    endcase
  end

  assign memWriteData = regB << {aluOut[1:0], 3'b000};  // aligned stores only
  assign memAddr = (ctl.adrSrc == rvCtrlPkg::adrAluOut) ? aluOut : pc;

  always_comb begin
    case (ctl.resultSrc)
      rvCtrlPkg::resultMdr:       result = loadData;
      rvCtrlPkg::resultAluResult: result = aluResult;
      default:                    result = aluOut;
    endcase
    case (ctl.pcSrc)
      rvCtrlPkg::pcAluOut:       pcNext = aluOut;
      rvCtrlPkg::pcAluResultClr: pcNext = {aluResult[rvIsaPkg::xlen-1:1], 1'b0};
      default:                   pcNext = result;  // pc + 4 from fetch
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= rvCtrlPkg::resetPc;
    end else if (ctl.pcUpdate) begin
      pc <= pcNext;
    end
  end

  always_ff @(posedge clk) begin
    if (ctl.irWrite) begin
      instr <= memReadData;
      oldPc <= pc;
    end
    mdr    <= memReadData;
    regA   <= rd1;
    regB   <= rd2;
    aluOut <= aluResult;
    if (ctl.regWrite && rd != 5'd0) begin
      regFile[rd] <= result;
    end
  end

endmodule

//--- verilog/rvCore.sv
// top level of the multicycle RV32I core, memory sits outside on plain ports
// combinational read, byte-enabled write at the clock edge
`timescale 1ns/1ps

module rvCore (
  input  logic           clk,
  input  logic           reset,
  input  rvIsaPkg::wordT memReadData,
  output rvIsaPkg::wordT memAddr,
  output rvIsaPkg::wordT memWriteData,
  output logic [3:0]     memByteEn,
  output logic [4:0]     fsmState
);

  rvCtrlPkg::fsmStateT state;

  ctrlIf ctl ();

  controlFsm i_controlFsm (
    .clk   (clk),
    .reset (reset),
    .ctl   (ctl.fsm),
    .state (state)
  );

  datapath i_datapath (
    .clk          (clk),
    .reset        (reset),
    .ctl          (ctl.dp),
    .memAddr      (memAddr),
    .memWriteData (memWriteData),
    .memReadData  (memReadData)
  );

  assign memByteEn = ctl.memByteEn;
  assign fsmState  = state;  // lets the testbench count fetch cycles

endmodule

//--- sim/rvCore_sva.sv
// assertions on the control FSM outputs, bound into every controlFsm instance
`timescale 1ns/1ps

module rvCore_sva (
  input logic       clk,
  input logic       reset,
  input logic [4:0] state,
  input logic       irWrite,
  input logic [3:0] memByteEn
);

  irWriteOnlyInFetch: assert property (
    @(posedge clk) disable iff (reset) irWrite |-> state == rvCtrlPkg::fetch
  ) else $error("irWrite high outside the fetch state");

  byteEnOnlyInMemWrite: assert property (
    @(posedge clk) disable iff (reset) (memByteEn != 4'b0000) |-> state == rvCtrlPkg::memWrite
  ) else $error("memByteEn nonzero outside the memWrite state");

  // a store always ends through primeFetch
  memWriteSequence: assert property (
    @(posedge clk) disable iff (reset)
      state == rvCtrlPkg::memWrite |=> state == rvCtrlPkg::primeFetch ##1 state == rvCtrlPkg::fetch
  ) else $error("memWrite not followed by primeFetch and fetch");

endmodule

bind controlFsm rvCore_sva i_rvCoreSva (
  .clk       (clk),
  .reset     (reset),
  .state     (state),
  .irWrite   (ctl.irWrite),
  .memByteEn (ctl.memByteEn)
);

//--- sim/rvCoreTb.sv
// testbench for the multicycle core with its program image, memory model and ISA reference
// a monitor checks every store and the cycles between fetches
`timescale 1ns/1ps

module rvCoreTb;

  logic        clk;
  logic        reset;
  logic [31:0] memReadData;
  logic [31:0] memAddr;
  logic [31:0] memWriteData;
  logic [3:0]  memByteEn;
  logic [4:0]  fsmState;

  logic [31:0] mem [1024];
  logic [31:0] refMem [1024];
  logic [31:0] refReg [32];

  // expected stores and cycles per instruction as rvRef finds them
  logic [31:0] expAddr [$];
  logic [3:0]  expMask [$];
  logic [31:0] expData [$];
  int          expCycles [$];

  int    progPc;
  int    storeOff;
  int    storeIdx;
  int    fetches;
  int    cycle;
  int    lastFetch;
  bit    done;
  int    checks [6];
  int    fails [6];
  string names [6];

  localparam int immTab [8] = '{-1234, 7, 100, -1, 'h5a5, 13, 'h0f0, -256};
  localparam int brF3 [6]   = '{0, 1, 4, 5, 6, 7};
  localparam int pairA [4]  = '{3, 4, 3, 3};
  localparam int pairB [4]  = '{4, 3, 5, 7};

  rvCore i_rvCore (
    .clk          (clk),
    .reset        (reset),
    .memReadData  (memReadData),
    .memAddr      (memAddr),
    .memWriteData (memWriteData),
    .memByteEn    (memByteEn),
    .fsmState     (fsmState)
  );

  always #10 clk = ~clk;

  assign memReadData = mem[memAddr[11:2]];  // combinational read

  always @(posedge clk) begin
    for (int l = 0; l < 4; l++) begin
      if (memByteEn[l]) mem[memAddr[11:2]][8*l +: 8] <= memWriteData[8*l +: 8];
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] encR(input int f7, input int rs2, input int rs1,
                                       input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] encI(input int imm, input int rs1, input int f3,
                                       input int rd, input logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] encS(input int imm, input int rs2, input int rs1, input int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] encB(input int imm, input int rs2, input int rs1, input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] encU(input logic [19:0] imm, input int rd, input logic [6:0] op);
    return {imm, rd[4:0], op};
  endfunction

  function automatic logic [31:0] encJ(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  task automatic emit(input logic [31:0] w);
    mem[progPc >> 2] = w;
    progPc += 4;
  endtask

  // instruction writing x6 followed by sw x6 into the next result slot
  task automatic emitStored(input logic [31:0] w);
    emit(w);
    emit(encS(storeOff, 6, 2, 2));
    storeOff += 4;
  endtask

  task automatic buildProgram();
    int m;
    progPc = 0;
    emit(encI('h400, 0, 0, 1, 7'h13));  // x1 data area
    emit(encI('h600, 0, 0, 2, 7'h13));  // x2 result area
    storeOff = 0;
    emit(encI(0, 1, 2, 3, 7'h03));
    emit(encI(4, 1, 2, 4, 7'h03));
    emit(encI(8, 1, 2, 5, 7'h03));
    for (int f = 0; f < 8; f++) emitStored(encR(0, 4, 3, f, 6));
    emitStored(encR('h20, 4, 3, 0, 6));
    emitStored(encR('h20, 4, 3, 5, 6));
    for (int f = 0; f < 8; f++) emitStored(encI(immTab[f], 3, f, 6, 7'h13));
    emitStored(encI('h40d, 3, 5, 6, 7'h13));  // srai by 13
    storeOff = 128;
    for (int k = 0; k < 4; k++) emitStored(encI(16 + k, 1, 0, 6, 7'h03));
    for (int k = 0; k < 4; k++) emitStored(encI(16 + k, 1, 4, 6, 7'h03));
    for (int k = 0; k < 4; k += 2) emitStored(encI(16 + k, 1, 1, 6, 7'h03));
    for (int k = 0; k < 4; k += 2) emitStored(encI(16 + k, 1, 5, 6, 7'h03));
    emitStored(encI(16, 1, 2, 6, 7'h03));
    for (int k = 0; k < 4; k++) emit(encS(storeOff + k, 3, 2, 0));
    storeOff += 4;
    emit(encS(storeOff, 3, 2, 1));
    emit(encS(storeOff + 2, 3, 2, 1));
    storeOff += 4;
    emit(encS(storeOff, 3, 2, 2));
    storeOff = 256;
    emit(encI(20, 1, 2, 3, 7'h03));
    emit(encI(24, 1, 2, 4, 7'h03));
    emit(encI(0, 3, 0, 5, 7'h13));       // x5 equals x3
    emit(encU(20'h80000, 8, 7'h37));
    emit(encR(0, 8, 3, 4, 7));           // x7 is x3 with the sign flipped
    m = 1;
    for (int p = 0; p < 4; p++) begin
      for (int b = 0; b < 6; b++) begin
        emit(encB(12, pairB[p], pairA[p], brF3[b]));
        emit(encI(m, 0, 0, 6, 7'h13));     // not-taken marker
        emit(encJ(8, 0));
        emit(encI(m + 1, 0, 0, 6, 7'h13)); // taken marker
        emit(encS(storeOff, 6, 2, 2));
        storeOff += 4;
        m += 2;
      end
    end
    storeOff = 384;
    emit(encJ(8, 7));
    emit(encI(0, 0, 0, 7, 7'h13));
    emit(encS(storeOff, 7, 2, 2));
    storeOff += 4;
    emitStored(encU(20'habcde, 6, 7'h37));
    emitStored(encU(20'h12345, 6, 7'h17));
    emit(32'h0ff0000f);                   // fence
    emit(encU(20'h0, 8, 7'h17));
    emit(encI(13, 8, 0, 9, 7'h67));       // odd target so bit 0 must clear
    emit(encI(0, 0, 0, 9, 7'h13));
    emit(encS(storeOff, 9, 2, 2));
    storeOff += 4;
    emitStored(encU(20'h0, 6, 7'h17));    // pc after jalr shows the cleared bit
    emit(encJ(0, 0));                     // park here
  endtask

  function automatic logic [31:0] aluCalc(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = {31'b0, $signed(a) < $signed(b)};
      3'd3: r = {31'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        r = a >> b[4:0];
        if (alt && a[31]) r = r | ~(32'hffff_ffff >> b[4:0]);  // sign fill for sra
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // runs the image in refMem up to the jump-to-self
  function automatic void rvRef();
    logic [31:0] pc, w, a, b, res, addr, word, sh, data, merged;
    logic [31:0] immI, immS, immB, immU, immJ, nextPc;
    logic [6:0]  op;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [3:0]  mask;
    logic        wr;
    logic        taken;
    int          steps;
    for (int i = 0; i < 32; i++) refReg[i] = '0;
    pc = rvCtrlPkg::resetPc;
    steps = 0;
    while (steps < 2000) begin
      w = refMem[pc[11:2]];
      if (w == 32'h0000006f) break;
      op = w[6:0];
      rd = w[11:7];
      f3 = w[14:12];
      a = refReg[w[19:15]];
      b = refReg[w[24:20]];
      immI = {{20{w[31]}}, w[31:20]};
      immS = {{20{w[31]}}, w[31:25], w[11:7]};
      immB = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      immU = {w[31:12], 12'b0};
      immJ = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      nextPc = pc + 4;
      wr = 1'b0;
      res = '0;
      case (op)
        7'h33: begin
          res = aluCalc(f3, w[30], a, b);
          wr = 1'b1;
          expCycles.push_back(4);
        end
        7'h13: begin
          res = aluCalc(f3, (f3 == 3'd5) && w[30], a, immI);
          wr = 1'b1;
          expCycles.push_back(4);
        end
        7'h03: begin
          addr = a + immI;
          word = refMem[addr[11:2]];
          sh = word >> {addr[1:0], 3'b000};
          case (f3)
            3'd0: res = {{24{sh[7]}}, sh[7:0]};
            3'd1: res = {{16{sh[15]}}, sh[15:0]};
            3'd4: res = {24'b0, sh[7:0]};
            3'd5: res = {16'b0, sh[15:0]};
            default: res = word;
          endcase
          wr = 1'b1;
          expCycles.push_back(5);
        end
        7'h23: begin
          addr = a + immS;
          case (f3)
            3'd0: mask = 4'b0001 << addr[1:0];
            3'd1: mask = 4'b0011 << addr[1:0];
            default: mask = 4'b1111;
          endcase
          data = b << {addr[1:0], 3'b000};
          merged = refMem[addr[11:2]];
          for (int l = 0; l < 4; l++) begin
            if (mask[l]) merged[8*l +: 8] = data[8*l +: 8];
          end
          refMem[addr[11:2]] = merged;
          expAddr.push_back(addr);
          expMask.push_back(mask);
          expData.push_back(merged);
          expCycles.push_back(5);
        end
        7'h63: begin
          case (f3)
            3'd0: taken = (a == b);
            3'd1: taken = (a != b);
            3'd4: taken = ($signed(a) < $signed(b));
            3'd5: taken = ($signed(a) >= $signed(b));
            3'd6: taken = (a < b);
            default: taken = (a >= b);
          endcase
          if (taken) nextPc = pc + immB;
          expCycles.push_back(3);
        end
        7'h6f: begin
          res = pc + 4;
          wr = 1'b1;
          nextPc = pc + immJ;
          expCycles.push_back(4);
        end
        7'h67: begin
          res = pc + 4;
          wr = 1'b1;
          nextPc = (a + immI) & 32'hffff_fffe;
          expCycles.push_back(5);
        end
        7'h37: begin
          res = immU;
          wr = 1'b1;
          expCycles.push_back(4);
        end
        7'h17: begin
          res = pc + immU;
          wr = 1'b1;
          expCycles.push_back(4);
        end
        default: expCycles.push_back(2);  // fence
      endcase
      if (wr && rd != 5'd0) refReg[rd] = res;
      pc = nextPc;
      steps++;
    end
  endfunction

  function automatic int testOf(input logic [31:0] addr);
    if (addr < 32'h600 || addr >= 32'h800) return 3;
    return int'((addr - 32'h600) >> 7);
  endfunction

  task automatic tally(input int t, input bit bad);
    checks[t]++;
    if (bad) fails[t]++;
  endtask

  task automatic checkStore();
    logic [31:0] merged;
    int          t;
    if (storeIdx >= expAddr.size()) begin
      $display("unexpected store to address %h after the last expected store", memAddr);
      tally(testOf(memAddr), 1'b1);
    end else begin
      merged = mem[memAddr[11:2]];
      for (int l = 0; l < 4; l++) begin
        if (memByteEn[l]) merged[8*l +: 8] = memWriteData[8*l +: 8];
      end
      t = testOf(expAddr[storeIdx]);
      if (memAddr !== expAddr[storeIdx] || memByteEn !== expMask[storeIdx] ||
          merged !== expData[storeIdx]) begin
        $display("Mismatch %s store %0d: expected %h mask %h data %h, actual %h mask %h data %h",
                 names[t], storeIdx, expAddr[storeIdx], expMask[storeIdx], expData[storeIdx],
                 memAddr, memByteEn, merged);
        tally(t, 1'b1);
      end else begin
        tally(t, 1'b0);
      end
      storeIdx++;
    end
  endtask

  // called on each falling edge where outputs are settled
  task automatic sampleCycle();
    if (fsmState == rvCtrlPkg::fetch) begin
      fetches++;
      if (fetches > 1) begin
        if (cycle - lastFetch != expCycles[fetches-2]) begin
          $display("Mismatch %s instruction %0d: expected %0d, actual %0d", names[4],
                   fetches - 2, expCycles[fetches-2], cycle - lastFetch);
          tally(4, 1'b1);
        end else begin
          tally(4, 1'b0);
        end
      end
      lastFetch = cycle;
      if (fetches == expCycles.size() + 1) done = 1'b1;
    end
    if (memByteEn != 4'b0000) checkStore();
  endtask

  initial begin
    logic [31:0] rng;
    int          errTotal;
    int          checkTotal;
    clk = 1'b0;
    reset = 1'b1;
    storeIdx = 0;
    fetches = 0;
    cycle = 0;
    lastFetch = 0;
    done = 1'b0;
    names = '{"arith", "loadStore", "branch", "jumpUpper", "cycles", "reset"};
    for (int t = 0; t < 6; t++) begin
      checks[t] = 0;
      fails[t] = 0;
    end
    for (int i = 0; i < 1024; i++) mem[i] = {2'b10, i[9:0], ~i[9:0], i[9:0]};
    rng = 32'h88cd6bed;
    for (int i = 0; i < 64; i++) begin
      rng = xorshift(rng);
      mem[256 + i] = rng;
    end
    buildProgram();
    for (int i = 0; i < 1024; i++) refMem[i] = mem[i];
    rvRef();

    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    if (memByteEn !== 4'b0000 || memAddr !== rvCtrlPkg::resetPc) begin
      $display("Mismatch reset: expected memByteEn 0 memAddr %h, actual memByteEn %h memAddr %h",
               rvCtrlPkg::resetPc, memByteEn, memAddr);
      tally(5, 1'b1);
    end else begin
      tally(5, 1'b0);
    end

    sampleCycle();
    while (!done) begin
      @(negedge clk);
      cycle++;
      sampleCycle();
      if (!done && cycle - lastFetch > 20) begin
        $display("timeout: no fetch state within 20 cycles, at cycle %0d", cycle);
        tally(4, 1'b1);
        done = 1'b1;
      end
    end
    if (storeIdx < expAddr.size()) begin
      $display("%0d expected stores never happened", expAddr.size() - storeIdx);
      tally(testOf(expAddr[storeIdx]), 1'b1);
    end

    errTotal = 0;
    checkTotal = 0;
    for (int t = 0; t < 6; t++) begin
      $display("test %s: %0d checks, %0d errors", names[t], checks[t], fails[t]);
      errTotal += fails[t];
      checkTotal += checks[t];
    end
    $display("tests 6, checks %0d, errors %0d", checkTotal, errTotal);
    if (errTotal == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog.f
verilog/rvIsaPkg.sv
verilog/rvCtrlPkg.sv
verilog/ctrlIf.sv
verilog/alu.sv
verilog/controlFsm.sv
verilog/datapath.sv
verilog/rvCore.sv
sim/rvCore_sva.sv
sim/rvCoreTb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rvCoreTb \
  -f verilog.f -o rvCoreSim \
  && ./obj_dir/rvCoreSim > sim.log 2>&1 \
  || echo "build or simulation failed" >> sim.log
cat sim.log
grep -q "Simulation finished: PASS" sim.log && exit 0 || exit 1
